// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/control_fsm.sv
`timescale 1ns/1ns

module control_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_isa_pkg::opcode_t opcode,
    input  cpu_isa_pkg::alu_op_t op,
    input  cpu_isa_pkg::cond_t   cond,
    input  logic                 n,
    input  logic                 v,
    input  logic                 z,
    output logic [2:0]           read_reg_sel,
    output logic [2:0]           write_reg_sel,
    output logic                 write,
    output logic [1:0]           vsel,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 load_c,
    output logic                 load_s,
    output logic                 asel,
    output logic                 bsel,
    output logic                 load_ir,
    output logic                 load_pc,
    output logic                 take_branch,
    output logic                 fetch,
    output logic                 load_addr,
    output logic                 access,
    output logic                 store,
    output logic                 halted
);
    // execute steps S_A..S_H must stay consecutive
    typedef enum logic [3:0] {
        S_RESET, S_FETCH, S_LOAD_IR, S_UPDATE, S_DECODE,
        S_A, S_B, S_C, S_D, S_E, S_F, S_G, S_H, S_HALT
    } state_t;

    localparam logic [1:0] MOV_REG     = 2'b00;
    localparam logic [1:0] MOV_IMM     = 2'b10;
    localparam logic [2:0] SEL_RN      = 3'b001;  // one-hot register field select
    localparam logic [2:0] SEL_RD      = 3'b010;
    localparam logic [2:0] SEL_RM      = 3'b100;
    localparam logic [1:0] VSEL_RESULT = 2'd0;
    localparam logic [1:0] VSEL_IMM    = 2'd1;
    localparam logic [1:0] VSEL_MEM    = 2'd2;

    state_t state;
    state_t next_state;
    logic   cond_met;
    logic   opcode_ok;
    logic   is_mov_imm;
    logic   is_mov_reg;
    logic   not_cmp;

    assign is_mov_imm = (opcode == cpu_isa_pkg::OP_MOV) && (op == MOV_IMM);
    assign is_mov_reg = (opcode == cpu_isa_pkg::OP_MOV) && (op == MOV_REG);
    assign not_cmp    = (op != cpu_isa_pkg::ALU_CMP);
    assign halted     = (state == S_HALT);

    always_comb
    begin
        case (cond)
            cpu_isa_pkg::COND_AL: cond_met = 1'b1;
            cpu_isa_pkg::COND_EQ: cond_met = z;
            cpu_isa_pkg::COND_NE: cond_met = !z;
            cpu_isa_pkg::COND_LT: cond_met = (n != v);
            cpu_isa_pkg::COND_LE: cond_met = (n != v) || z;
            default:              cond_met = 1'b0;
        endcase
    end

    // anything not listed here ends in the halt state
    always_comb
    begin
        case (opcode)
            cpu_isa_pkg::OP_MOV:    opcode_ok = is_mov_imm || is_mov_reg;
            cpu_isa_pkg::OP_ALU,
            cpu_isa_pkg::OP_LDR,
            cpu_isa_pkg::OP_STR:    opcode_ok = 1'b1;
            cpu_isa_pkg::OP_BRANCH: opcode_ok = (cond <= cpu_isa_pkg::COND_LE);
            cpu_isa_pkg::OP_HALT:   opcode_ok = 1'b0;
            default:                opcode_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        read_reg_sel  = SEL_RN;
        write_reg_sel = SEL_RD;
        write         = 1'b0;
        vsel          = VSEL_RESULT;
        load_a        = 1'b0;
        load_b        = 1'b0;
        load_c        = 1'b0;
        load_s        = 1'b0;
        asel          = 1'b0;
        bsel          = 1'b0;
        load_ir       = 1'b0;
        load_pc       = 1'b0;
        take_branch   = 1'b0;
        fetch         = 1'b0;
        load_addr     = 1'b0;
        access        = 1'b0;
        store         = 1'b0;
        next_state    = state_t'(state + 4'd1);
        case (state)
            S_RESET:   fetch = 1'b1;
            S_FETCH: ;  // instruction request on the bus
            S_LOAD_IR: load_ir = 1'b1;
            S_UPDATE:  load_pc = (opcode != cpu_isa_pkg::OP_BRANCH);  // branch steps own the pc
            S_DECODE:  next_state = opcode_ok ? S_A : S_HALT;
            S_A:
            begin
                if (is_mov_imm)
                begin
                    write_reg_sel = SEL_RN;
                    vsel          = VSEL_IMM;
                    write         = 1'b1;
                    fetch         = 1'b1;
                end
                else if (is_mov_reg)
                begin
                    read_reg_sel = SEL_RM;
                    load_b       = 1'b1;
                end
                else if (opcode == cpu_isa_pkg::OP_BRANCH)
                begin
                    load_pc     = 1'b1;
                    take_branch = cond_met;
                    fetch       = 1'b1;
                end
                else
                    load_a = 1'b1;  // base or first operand from Rn
            end
            S_B:
            begin
                if (is_mov_reg)
                begin
                    asel   = 1'b1;
                    load_c = 1'b1;
                end
                else
                begin
                    read_reg_sel = SEL_RM;
                    load_b       = 1'b1;
                end
            end
            S_C:
            begin
                if (is_mov_reg)
                begin
                    write = 1'b1;
                    fetch = 1'b1;
                end
                else if (opcode == cpu_isa_pkg::OP_ALU)
                begin
                    load_c = not_cmp;
                    load_s = 1'b1;
                end
                else
                begin
                    bsel   = 1'b1;  // Rn + sximm5
                    load_c = 1'b1;
                end
            end
            S_D:
            begin
                if (opcode == cpu_isa_pkg::OP_ALU)
                begin
                    write = not_cmp;
                    fetch = 1'b1;
                end
                else
                begin
                    load_addr = 1'b1;
                    access    = (opcode == cpu_isa_pkg::OP_LDR);
                end
            end
            S_E: ;  // load request on the bus
            S_F:
            begin
                if (opcode == cpu_isa_pkg::OP_LDR)
                begin
                    vsel  = VSEL_MEM;
                    write = 1'b1;
                    fetch = 1'b1;
                end
                else
                begin
                    read_reg_sel = SEL_RD;
                    load_b       = 1'b1;
                end
            end
            S_G:
            begin
                asel   = 1'b1;  // store data into C
                load_c = 1'b1;
                access = 1'b1;
                store  = 1'b1;
            end
            S_H:       fetch = 1'b1;
            default:   next_state = S_HALT;
        endcase
        if (fetch)
            next_state = S_FETCH;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_RESET;
        else
            state <= next_state;
    end

endmodule

// File: design/cpu_bus_pkg.sv
package cpu_bus_pkg;

    localparam int WORD_W = 16;  // data width
    localparam int ADDR_W = 9;   // word address width

    typedef logic [1:0] mem_cmd_t;

    localparam mem_cmd_t MEM_NONE  = 2'b00;
    localparam mem_cmd_t MEM_READ  = 2'b01;
    localparam mem_cmd_t MEM_WRITE = 2'b11;

endpackage

// File: design/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [2:0] opcode_t;
    typedef logic [1:0] alu_op_t;
    typedef logic [1:0] shift_t;
    typedef logic [2:0] cond_t;

    localparam int REG_ADDR_W = 3;

    localparam opcode_t OP_BRANCH = 3'b001;
    localparam opcode_t OP_LDR    = 3'b011;
    localparam opcode_t OP_STR    = 3'b100;
    localparam opcode_t OP_ALU    = 3'b101;
    localparam opcode_t OP_MOV    = 3'b110;
    localparam opcode_t OP_HALT   = 3'b111;

    localparam alu_op_t ALU_ADD = 2'b00;
    localparam alu_op_t ALU_CMP = 2'b01;  // subtract, flags only
    localparam alu_op_t ALU_AND = 2'b10;
    localparam alu_op_t ALU_MVN = 2'b11;

    localparam shift_t SH_NONE = 2'b00;
    localparam shift_t SH_LEFT = 2'b01;
    localparam shift_t SH_LSR  = 2'b10;
    localparam shift_t SH_ASR  = 2'b11;

    localparam cond_t COND_AL = 3'b000;
    localparam cond_t COND_EQ = 3'b001;
    localparam cond_t COND_NE = 3'b010;
    localparam cond_t COND_LT = 3'b011;
    localparam cond_t COND_LE = 3'b100;

    // instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 13;
    localparam int OP_MSB     = 12;
    localparam int OP_LSB     = 11;
    localparam int RN_MSB     = 10;
    localparam int RN_LSB     = 8;
    localparam int RD_MSB     = 7;
    localparam int RD_LSB     = 5;
    localparam int SHIFT_MSB  = 4;
    localparam int SHIFT_LSB  = 3;
    localparam int RM_MSB     = 2;
    localparam int RM_LSB     = 0;
    localparam int IMM8_MSB   = 7;
    localparam int IMM8_LSB   = 0;
    localparam int IMM5_MSB   = 4;
    localparam int IMM5_LSB   = 0;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
    parameter logic [cpu_bus_pkg::ADDR_W-1:0] RESET_PC = '0,
    parameter int                             NUM_REGS = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_bus_pkg::WORD_W-1:0] read_data,
    output cpu_bus_pkg::mem_cmd_t          mem_cmd,
    output logic [cpu_bus_pkg::ADDR_W-1:0] mem_addr,
    output logic [cpu_bus_pkg::WORD_W-1:0] write_data,
    output logic                           n,
    output logic                           v,
    output logic                           z,
    output logic                           halted
);
    localparam int RW = cpu_isa_pkg::REG_ADDR_W;

    logic [cpu_bus_pkg::WORD_W-1:0] instr;
    logic [cpu_bus_pkg::WORD_W-1:0] sximm5;
    logic [cpu_bus_pkg::WORD_W-1:0] sximm8;
    logic [cpu_bus_pkg::WORD_W-1:0] result;
    logic [cpu_bus_pkg::ADDR_W-1:0] branch_offset;
    logic [cpu_bus_pkg::ADDR_W-1:0] pc;
    logic [cpu_bus_pkg::ADDR_W-1:0] data_addr;
    cpu_isa_pkg::opcode_t           opcode;
    cpu_isa_pkg::alu_op_t           op;
    cpu_isa_pkg::cond_t             cond;
    cpu_isa_pkg::shift_t            shift;
    logic [RW-1:0]                  rn;
    logic [RW-1:0]                  rd;
    logic [RW-1:0]                  rm;
    logic [RW-1:0]                  read_reg;
    logic [RW-1:0]                  write_reg;
    logic [2:0]                     read_reg_sel;
    logic [2:0]                     write_reg_sel;
    logic [1:0]                     vsel;
    logic write, load_a, load_b, load_c, load_s, asel, bsel;
    logic load_ir, load_pc, take_branch, fetch, fetch_req;
    logic load_addr, access, store, data_req, data_write;

    // selects are one-hot: bit 0 Rn, bit 1 Rd, bit 2 Rm
    assign read_reg  = ({RW{read_reg_sel[0]}} & rn) | ({RW{read_reg_sel[1]}} & rd)
                     | ({RW{read_reg_sel[2]}} & rm);
    assign write_reg = ({RW{write_reg_sel[0]}} & rn) | ({RW{write_reg_sel[1]}} & rd)
                     | ({RW{write_reg_sel[2]}} & rm);
    assign write_data = result;

    instr_decoder decoder_i (
        .instr, .opcode, .op, .cond, .rn, .rd, .rm, .shift,
        .sximm5, .sximm8, .branch_offset
    );

    control_fsm fsm_i (
        .clk, .reset, .opcode, .op, .cond, .n, .v, .z,
        .read_reg_sel, .write_reg_sel, .write, .vsel,
        .load_a, .load_b, .load_c, .load_s, .asel, .bsel,
        .load_ir, .load_pc, .take_branch, .fetch,
        .load_addr, .access, .store, .halted
    );

    datapath #(.NUM_REGS(NUM_REGS)) datapath_i (
        .clk, .reset, .read_reg, .write_reg, .write, .vsel,
        .load_a, .load_b, .load_c, .load_s, .asel, .bsel,
        .shift, .alu_op(op), .sximm8, .sximm5, .mdata(read_data),
        .result, .n, .v, .z
    );

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
        .clk, .reset, .load_ir, .load_pc, .take_branch, .fetch,
        .read_data, .branch_offset, .instr, .pc, .fetch_req
    );

    load_store_unit lsu_i (
        .clk, .reset, .load_addr, .access, .store, .result,
        .data_addr, .data_req, .data_write
    );

    mem_arbiter arbiter_i (
        .fetch_req, .pc, .data_req, .data_write, .data_addr,
        .mem_cmd, .mem_addr
    );

endmodule

// File: design/datapath.sv
`timescale 1ns/1ns

module datapath #(
    parameter int NUM_REGS = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] read_reg,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] write_reg,
    input  logic                               write,
    input  logic [1:0]                         vsel,
    input  logic                               load_a,
    input  logic                               load_b,
    input  logic                               load_c,
    input  logic                               load_s,
    input  logic                               asel,
    input  logic                               bsel,
    input  cpu_isa_pkg::shift_t                shift,
    input  cpu_isa_pkg::alu_op_t               alu_op,
    input  logic [cpu_bus_pkg::WORD_W-1:0]     sximm8,
    input  logic [cpu_bus_pkg::WORD_W-1:0]     sximm5,
    input  logic [cpu_bus_pkg::WORD_W-1:0]     mdata,
    output logic [cpu_bus_pkg::WORD_W-1:0]     result,
    output logic                               n,
    output logic                               v,
    output logic                               z
);
    localparam int W   = cpu_bus_pkg::WORD_W;
    localparam int MSB = W - 1;

    logic [W-1:0] regs [NUM_REGS];
    logic [W-1:0] data_in;
    logic [W-1:0] a_reg;
    logic [W-1:0] b_reg;
    logic [W-1:0] b_shift;
    logic [W-1:0] a_in;
    logic [W-1:0] b_in;
    logic [W-1:0] alu_out;
    logic         alu_v;

    always_comb
    begin
        case (vsel)
            2'd1:    data_in = sximm8;
            2'd2:    data_in = mdata;
            default: data_in = result;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (write)
            regs[write_reg] <= data_in;
        if (load_a)
            a_reg <= regs[read_reg];
        if (load_b)
            b_reg <= regs[read_reg];
        if (load_c)
            result <= alu_out;
    end

    always_comb
    begin
        case (shift)
            cpu_isa_pkg::SH_NONE: b_shift = b_reg;
            cpu_isa_pkg::SH_LEFT: b_shift = {b_reg[MSB-1:0], 1'b0};
            cpu_isa_pkg::SH_LSR:  b_shift = {1'b0, b_reg[MSB:1]};
            cpu_isa_pkg::SH_ASR:  b_shift = {b_reg[MSB], b_reg[MSB:1]};
        endcase
    end

    assign a_in = asel ? '0 : a_reg;
    assign b_in = bsel ? sximm5 : b_shift;

    always_comb
    begin
        alu_v = 1'b0;
        case (alu_op)
            cpu_isa_pkg::ALU_ADD:
            begin
                alu_out = a_in + b_in;
                alu_v   = (a_in[MSB] == b_in[MSB]) && (alu_out[MSB] != a_in[MSB]);
            end
            cpu_isa_pkg::ALU_CMP:
            begin
                alu_out = a_in - b_in;
                alu_v   = (a_in[MSB] != b_in[MSB]) && (alu_out[MSB] != a_in[MSB]);
            end
            cpu_isa_pkg::ALU_AND: alu_out = a_in & b_in;
            cpu_isa_pkg::ALU_MVN: alu_out = ~b_in;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
        end
        else if (load_s)
        begin
            n <= alu_out[MSB];
            v <= alu_v;
            z <= (alu_out == '0);
        end
    end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter logic [cpu_bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_ir,
    input  logic                           load_pc,
    input  logic                           take_branch,
    input  logic                           fetch,
    input  logic [cpu_bus_pkg::WORD_W-1:0] read_data,
    input  logic [cpu_bus_pkg::ADDR_W-1:0] branch_offset,
    output logic [cpu_bus_pkg::WORD_W-1:0] instr,
    output logic [cpu_bus_pkg::ADDR_W-1:0] pc,
    output logic                           fetch_req
);
    logic [cpu_bus_pkg::ADDR_W-1:0] next_pc;

    assign next_pc = pc + 1'b1 + (take_branch ? branch_offset : '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc        <= RESET_PC;
            fetch_req <= 1'b0;
        end
        else
        begin
            fetch_req <= fetch;  // request goes out the cycle after the strobe
            if (load_pc)
                pc <= next_pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_ir)
            instr <= read_data;
    end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic [cpu_bus_pkg::WORD_W-1:0]     instr,
    output cpu_isa_pkg::opcode_t               opcode,
    output cpu_isa_pkg::alu_op_t               op,
    output cpu_isa_pkg::cond_t                 cond,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rn,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rd,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0] rm,
    output cpu_isa_pkg::shift_t                shift,
    output logic [cpu_bus_pkg::WORD_W-1:0]     sximm5,
    output logic [cpu_bus_pkg::WORD_W-1:0]     sximm8,
    output logic [cpu_bus_pkg::ADDR_W-1:0]     branch_offset
);
    localparam int W      = cpu_bus_pkg::WORD_W;
    localparam int IMM5_W = cpu_isa_pkg::IMM5_MSB - cpu_isa_pkg::IMM5_LSB + 1;
    localparam int IMM8_W = cpu_isa_pkg::IMM8_MSB - cpu_isa_pkg::IMM8_LSB + 1;

    logic [IMM5_W-1:0] imm5;
    logic [IMM8_W-1:0] imm8;

    assign opcode = instr[cpu_isa_pkg::OPCODE_MSB:cpu_isa_pkg::OPCODE_LSB];
    assign op     = instr[cpu_isa_pkg::OP_MSB:cpu_isa_pkg::OP_LSB];
    assign rn     = instr[cpu_isa_pkg::RN_MSB:cpu_isa_pkg::RN_LSB];
    assign rd     = instr[cpu_isa_pkg::RD_MSB:cpu_isa_pkg::RD_LSB];
    assign rm     = instr[cpu_isa_pkg::RM_MSB:cpu_isa_pkg::RM_LSB];
    assign cond   = rn;  // branch condition sits in the Rn field
    assign imm5   = instr[cpu_isa_pkg::IMM5_MSB:cpu_isa_pkg::IMM5_LSB];
    assign imm8   = instr[cpu_isa_pkg::IMM8_MSB:cpu_isa_pkg::IMM8_LSB];

    assign sximm5        = {{(W - IMM5_W){imm5[IMM5_W-1]}}, imm5};
    assign sximm8        = {{(W - IMM8_W){imm8[IMM8_W-1]}}, imm8};
    assign branch_offset = {{(cpu_bus_pkg::ADDR_W - IMM8_W){imm8[IMM8_W-1]}}, imm8};

    // bits 4:3 belong to imm5 or imm8 in these formats
    always_comb
    begin
        case (opcode)
            cpu_isa_pkg::OP_LDR,
            cpu_isa_pkg::OP_STR,
            cpu_isa_pkg::OP_BRANCH: shift = cpu_isa_pkg::SH_NONE;
            default:                shift = instr[cpu_isa_pkg::SHIFT_MSB:cpu_isa_pkg::SHIFT_LSB];
        endcase
    end

endmodule

// File: design/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_addr,
    input  logic                           access,
    input  logic                           store,
    input  logic [cpu_bus_pkg::WORD_W-1:0] result,
    output logic [cpu_bus_pkg::ADDR_W-1:0] data_addr,
    output logic                           data_req,
    output logic                           data_write
);

    always_ff @(posedge clk)
    begin
        if (load_addr)
            data_addr <= result[cpu_bus_pkg::ADDR_W-1:0];  // word address from C
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_req   <= 1'b0;
            data_write <= 1'b0;
        end
        else
        begin
            data_req   <= access;
            data_write <= access && store;
        end
    end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                           fetch_req,
    input  logic [cpu_bus_pkg::ADDR_W-1:0] pc,
    input  logic                           data_req,
    input  logic                           data_write,
    input  logic [cpu_bus_pkg::ADDR_W-1:0] data_addr,
    output cpu_bus_pkg::mem_cmd_t          mem_cmd,
    output logic [cpu_bus_pkg::ADDR_W-1:0] mem_addr
);

    // data side has fixed priority
    always_comb
    begin
        if (data_req)
        begin
            mem_cmd  = data_write ? cpu_bus_pkg::MEM_WRITE : cpu_bus_pkg::MEM_READ;
            mem_addr = data_addr;
        end
        else if (fetch_req)
        begin
            mem_cmd  = cpu_bus_pkg::MEM_READ;
            mem_addr = pc;
        end
        else
        begin
            mem_cmd  = cpu_bus_pkg::MEM_NONE;
            mem_addr = pc;  // idle address
        end
    end

endmodule

// File: list.f
+incdir+test
design/cpu_isa_pkg.sv
design/cpu_bus_pkg.sv
design/instr_decoder.sv
design/datapath.sv
design/control_fsm.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/mem_arbiter.sv
design/cpu_top.sv
test/cpu_sva.sv
test/cpu_tb.sv

// File: test/cpu_sva.sv
`timescale 1ns/1ns

module cpu_sva (
    input logic                  clk,
    input logic                  reset,
    input cpu_bus_pkg::mem_cmd_t mem_cmd,
    input logic                  halted
);

    // a stopped core keeps the memory port idle
    quiet_when_halted: assert property (
        @(posedge clk) disable iff (reset)
        halted |-> mem_cmd == cpu_bus_pkg::MEM_NONE
    ) else $error("memory command seen while the core is halted");

    // the fetch request is registered, so the first cycle out of reset is idle
    idle_after_reset: assert property (
        @(posedge clk) $past(reset) && !reset |-> mem_cmd == cpu_bus_pkg::MEM_NONE
    ) else $error("memory command seen in the first cycle after reset");

    halt_is_sticky: assert property (
        @(posedge clk) halted && !reset |=> halted
    ) else $error("halted dropped without a reset");

endmodule

bind cpu_top cpu_sva sva_i (
    .clk,
    .reset,
    .mem_cmd,
    .halted
);

// File: test/cpu_programs.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

localparam int NUM_PROGS = 5;

localparam logic [15:0] HALT_WORD  = {cpu_isa_pkg::OP_HALT, 13'd0};
localparam logic [15:0] UNDEF_WORD = 16'h4000;  // opcode 010 is not defined

// code, result address, expected word and optional n/v/z check per program
logic [15:0] prog          [NUM_PROGS][PROG_WORDS];
logic [8:0]  result_addr   [NUM_PROGS];
logic [15:0] expected_word [NUM_PROGS];
logic        flag_check    [NUM_PROGS];
logic [2:0]  expected_nvz  [NUM_PROGS];

task automatic set_expectation(input int p, input logic [8:0] addr, input logic [15:0] word,
                               input logic chk, input logic [2:0] nvz);
    result_addr[p]   = addr;
    expected_word[p] = word;
    flag_check[p]    = chk;
    expected_nvz[p]  = nvz;
endtask

task automatic build_program_table();
    for (int p = 0; p < NUM_PROGS; p++)
    begin
        for (int k = 0; k < PROG_WORDS; k++)
            prog[p][k] = HALT_WORD;
    end

    // 0xFFC3 asr -> 0xFFE1, lsl -> 0xFFC2, lsr -> 0x7FE1
    prog[0][0] = mov_imm(3'd0, 8'hC3);
    prog[0][1] = mov_reg(3'd1, 3'd0, cpu_isa_pkg::SH_ASR);
    prog[0][2] = mov_reg(3'd2, 3'd1, cpu_isa_pkg::SH_LEFT);
    prog[0][3] = mov_reg(3'd3, 3'd2, cpu_isa_pkg::SH_LSR);
    prog[0][4] = mov_imm(3'd4, 8'd100);
    prog[0][5] = str_instr(3'd3, 3'd4, 5'd0);
    set_expectation(0, 9'd100, 16'h7FE1, 1'b0, 3'b000);

    // mvn gives 0x8000, 0xFFFF + 0x8000 wraps to 0x7FFF, and with 0x00B4 leaves 0x00B4
    prog[1][0] = mov_imm(3'd1, 8'hFF);
    prog[1][1] = alu_instr(cpu_isa_pkg::ALU_MVN, 3'd2, 3'd1, 3'd1, cpu_isa_pkg::SH_LSR);
    prog[1][2] = alu_instr(cpu_isa_pkg::ALU_ADD, 3'd3, 3'd1, 3'd2, cpu_isa_pkg::SH_NONE);
    prog[1][3] = mov_imm(3'd0, 8'h5A);
    prog[1][4] = alu_instr(cpu_isa_pkg::ALU_AND, 3'd4, 3'd3, 3'd0, cpu_isa_pkg::SH_LEFT);
    prog[1][5] = alu_instr(cpu_isa_pkg::ALU_ADD, 3'd5, 3'd4, 3'd2, cpu_isa_pkg::SH_NONE);
    prog[1][6] = mov_imm(3'd6, 8'd101);
    prog[1][7] = str_instr(3'd5, 3'd6, 5'd2);
    prog[1][8] = alu_instr(cpu_isa_pkg::ALU_CMP, 3'd5, 3'd3, 3'd3, cpu_isa_pkg::SH_NONE);
    set_expectation(1, 9'd103, 16'h80B4, 1'b1, 3'b001);  // equal compare sets only z

    // store at 120 - 3, load back, store at 124
    prog[2][0] = mov_imm(3'd0, 8'hA5);
    prog[2][1] = mov_imm(3'd1, 8'd120);
    prog[2][2] = str_instr(3'd0, 3'd1, 5'h1D);
    prog[2][3] = ldr_instr(3'd2, 3'd1, 5'h1D);
    prog[2][4] = str_instr(3'd2, 3'd1, 5'd4);
    set_expectation(2, 9'd124, 16'hFFA5, 1'b0, 3'b000);

    // five passes leave 0x45; BLT taken skips the doubling, BLE falls through to lsl
    prog[3][0]  = mov_imm(3'd0, 8'd5);
    prog[3][1]  = mov_imm(3'd1, 8'hFF);
    prog[3][2]  = mov_imm(3'd3, 8'd1);
    prog[3][3]  = mov_imm(3'd2, 8'h40);
    prog[3][4]  = alu_instr(cpu_isa_pkg::ALU_ADD, 3'd2, 3'd2, 3'd3, cpu_isa_pkg::SH_NONE);
    prog[3][5]  = alu_instr(cpu_isa_pkg::ALU_ADD, 3'd0, 3'd0, 3'd1, cpu_isa_pkg::SH_NONE);
    prog[3][6]  = branch_instr(cpu_isa_pkg::COND_NE, 8'hFD);
    prog[3][7]  = alu_instr(cpu_isa_pkg::ALU_CMP, 3'd0, 3'd3, 3'd2, cpu_isa_pkg::SH_NONE);
    prog[3][8]  = branch_instr(cpu_isa_pkg::COND_LT, 8'd1);
    prog[3][9]  = alu_instr(cpu_isa_pkg::ALU_ADD, 3'd2, 3'd2, 3'd2, cpu_isa_pkg::SH_NONE);
    prog[3][10] = alu_instr(cpu_isa_pkg::ALU_CMP, 3'd0, 3'd2, 3'd3, cpu_isa_pkg::SH_NONE);
    prog[3][11] = branch_instr(cpu_isa_pkg::COND_LE, 8'd1);
    prog[3][12] = mov_reg(3'd2, 3'd2, cpu_isa_pkg::SH_LEFT);
    prog[3][13] = mov_imm(3'd5, 8'd110);
    prog[3][14] = str_instr(3'd2, 3'd5, 5'd0);
    set_expectation(3, 9'd110, 16'h008A, 1'b1, 3'b000);

    // BEQ and B skip the wrong moves, then the undefined word stops the core
    prog[4][0]  = mov_imm(3'd0, 8'h2B);
    prog[4][1]  = mov_imm(3'd1, 8'd90);
    prog[4][2]  = alu_instr(cpu_isa_pkg::ALU_CMP, 3'd0, 3'd0, 3'd0, cpu_isa_pkg::SH_NONE);
    prog[4][3]  = branch_instr(cpu_isa_pkg::COND_EQ, 8'd1);
    prog[4][4]  = mov_imm(3'd0, 8'h11);
    prog[4][5]  = branch_instr(cpu_isa_pkg::COND_AL, 8'd1);
    prog[4][6]  = mov_imm(3'd0, 8'h22);
    prog[4][7]  = str_instr(3'd0, 3'd1, 5'd0);
    prog[4][8]  = UNDEF_WORD;
    prog[4][9]  = mov_imm(3'd0, 8'h33);
    prog[4][10] = str_instr(3'd0, 3'd1, 5'd0);
    set_expectation(4, 9'd90, 16'h002B, 1'b1, 3'b001);
endtask

`endif

// File: test/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    localparam int          CLK_HALF     = 10;
    localparam int          RESET_CYCLES = 8;
    localparam int          HALT_TIMEOUT = 2000;
    localparam int          QUIET_CYCLES = 50;
    localparam int          MEM_WORDS    = 512;
    localparam int          PROG_WORDS   = 16;
    localparam logic [31:0] SEED         = 32'h97b0;

    logic                           clk = 1'b0;
    logic                           reset;
    logic [cpu_bus_pkg::WORD_W-1:0] read_data = '0;
    cpu_bus_pkg::mem_cmd_t          mem_cmd;
    logic [cpu_bus_pkg::ADDR_W-1:0] mem_addr;
    logic [cpu_bus_pkg::WORD_W-1:0] write_data;
    logic                           n;
    logic                           v;
    logic                           z;
    logic                           halted;

    logic [15:0] mem    [MEM_WORDS];
    logic [15:0] image  [MEM_WORDS];  // next memory contents to copy in on load_mem
    logic [15:0] frozen [MEM_WORDS];
    logic        load_mem;

    function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm8);
        return {cpu_isa_pkg::OP_MOV, 2'b10, rn, imm8};
    endfunction

    function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [2:0] rm,
                                            input cpu_isa_pkg::shift_t sh);
        return {cpu_isa_pkg::OP_MOV, 2'b00, 3'd0, rd, sh, rm};
    endfunction

    function automatic logic [15:0] alu_instr(input cpu_isa_pkg::alu_op_t op,
                                              input logic [2:0] rd, input logic [2:0] rn,
                                              input logic [2:0] rm,
                                              input cpu_isa_pkg::shift_t sh);
        return {cpu_isa_pkg::OP_ALU, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [15:0] ldr_instr(input logic [2:0] rd, input logic [2:0] rn,
                                              input logic [4:0] imm5);
        return {cpu_isa_pkg::OP_LDR, 2'b00, rn, rd, imm5};
    endfunction

    function automatic logic [15:0] str_instr(input logic [2:0] rd, input logic [2:0] rn,
                                              input logic [4:0] imm5);
        return {cpu_isa_pkg::OP_STR, 2'b00, rn, rd, imm5};
    endfunction

    // target is the branch address plus one plus the offset
    function automatic logic [15:0] branch_instr(input cpu_isa_pkg::cond_t cond,
                                                 input logic [7:0] offset);
        return {cpu_isa_pkg::OP_BRANCH, 2'b00, cond, offset};
    endfunction

    `include "cpu_programs.svh"

    cpu_top #(
        .RESET_PC('0),
        .NUM_REGS(8)
    ) cpu_top_i (
        .clk,
        .reset,
        .read_data,
        .mem_cmd,
        .mem_addr,
        .write_data,
        .n,
        .v,
        .z,
        .halted
    );

    always #CLK_HALF clk = ~clk;

    // synchronous memory with read data one cycle after the command
    always @(posedge clk)
    begin
        if (load_mem)
        begin
            for (int a = 0; a < MEM_WORDS; a++)
                mem[a] <= image[a];
        end
        else if (mem_cmd == cpu_bus_pkg::MEM_WRITE)
            mem[mem_addr] <= write_data;
        if (mem_cmd == cpu_bus_pkg::MEM_READ)
            read_data <= mem[mem_addr];
    end

    task automatic check_value(input string what, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic fill_image(input int p);
        for (int a = 0; a < MEM_WORDS; a++)
            image[a] = 16'($urandom);  // random background so stale words cannot match
        for (int k = 0; k < PROG_WORDS; k++)
            image[k] = prog[p][k];
    endtask

    task automatic reset_core(input int p);
        @(posedge clk);
        reset <= 1'b1;
        fill_image(p);
        load_mem <= 1'b1;
        @(posedge clk);
        load_mem <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_halt(input int p);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!halted)
        begin
            $display("Program %0d: the core did not halt within %0d cycles", p, HALT_TIMEOUT);
            $display("TESTS FAILED");
            $fatal(1, "halt timeout");
        end
    endtask

    task automatic check_memory_frozen(input int p);
        for (int a = 0; a < MEM_WORDS; a++)
            frozen[a] = mem[a];
        repeat (QUIET_CYCLES) @(negedge clk);
        for (int a = 0; a < MEM_WORDS; a++)
            check_value($sformatf("program %0d word %0d after halt", p, a), mem[a], frozen[a]);
    endtask

    task automatic run_program(input int p);
        reset_core(p);
        wait_for_halt(p);
        @(negedge clk);
        check_value($sformatf("program %0d result word", p), mem[result_addr[p]],
                    expected_word[p]);
        if (flag_check[p])
        begin
            check_value($sformatf("program %0d flags nvz", p), {13'd0, n, v, z},
                        {13'd0, expected_nvz[p]});
            // C still holds the last stored word
            check_value($sformatf("program %0d result register", p), write_data,
                        expected_word[p]);
        end
        check_memory_frozen(p);
    endtask

    initial
    begin
        reset    = 1'b1;
        load_mem = 1'b0;
        void'($urandom(SEED));
        build_program_table();
        for (int p = 0; p < NUM_PROGS; p++)
            run_program(p);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
